// File: dv/spi_ctrl_input.txt
// columns: kind a b c d (hex)
// kind 1 write: frame, reg (0 led 1 dac 2 rails 3 adc 4 clamp 5 relay 6 irange, e none, f reset), value, readback
// kind 2 bad frame: frame, bit count, special_n, 0    kind 3 route: mux, periph_cs_n, 0, 0
1 0705 0 5 0705  // led set
1 070a 0 f 070f
1 0730 0 c 070c  // led clear
1 0766 0 a 070a  // led toggle
1 0913 1 1 0901  // partial overlap, toggle only
1 0a0f 2 f 0a0f
1 0e03 3 3 0e03
1 0f09 4 9 0f09
1 1306 5 6 1306
1 14a0 6 5 1405  // clear from reset value
1 14ff 6 a 140a
2 070f f 0 0     // 15 bits
2 0a30 11 0 0    // 17 bits
2 0e0c 10 1 0    // special_n high
1 0305 e 0 0000  // unknown address
3 0001 e 0 0
3 0006 9 0 0
3 000f 0 0 0
1 0b00 f 0 0000  // soft reset
1 0703 0 3 0703
1 1322 5 2 1302
1 1410 6 e 140e

// File: filelist.f
+incdir+include
rtl/spi_frame_pkg.sv
rtl/ctrl_reg_pkg.sv
rtl/spi_frame_rx.sv
rtl/ctrl_reg_bank.sv
rtl/periph_spi_router.sv
rtl/spi_ctrl_top.sv
dv/spi_ctrl_properties.sv
dv/spi_ctrl_tb.sv

// File: Makefile
# Verilator flow for the control FPGA testbench
#   make        build and run, result taken from the log
#   make lint   lint RTL and testbench
#   make clean  remove build output

VERILATOR ?= verilator
TOP       ?= spi_ctrl_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qxF -- '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/spi_ctrl_tb.sv
////////////////////////////////////////////////////////////
// control FPGA testbench
// file driven SPI frames, register, readback and routing checks
////////////////////////////////////////////////////////////

`include "spi_ctrl_cfg.svh"

module spi_ctrl_tb;

  import spi_frame_pkg::*;
  import ctrl_reg_pkg::*;

  localparam int max_recs  = 64;
  localparam int rec_words = 5;  // kind, a, b, c, d
  localparam int half_bit  = 4;  // clk cycles per sclk phase

  logic        clk;
  logic        arst_n;
  logic        sclk, cs_n, special_n, mosi, miso;
  logic        periph_sclk, periph_mosi;
  periph_vec_t periph_cs_n, periph_miso;
  nib_t        led, dac, rails, adc, clamp, relay, irange_sense;

  logic [15:0] vec_mem [0:max_recs*rec_words-1];
  int          num_recs;
  logic        loaded = 1'b0;
  integer      seed;
  nib_t        shadow [0:6];  // expected register contents
  frame_t      last_rb;       // readback of last accepted frame

  spi_ctrl_top spi_ctrl_top_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // period 8
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive point just past the edge
  endtask

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_nib(input string name, input nib_t got, input nib_t exp);
    if (got !== exp)
      stop_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_frame(input string name, input frame_t got, input frame_t exp);
    if (got !== exp)
      stop_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_periph(input string name, input periph_vec_t got,
                              input periph_vec_t exp);
    if (got !== exp)
      stop_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic reset_shadow();
    for (int i = 0; i < 6; i++)
      shadow[i] = '0;
    shadow[6] = `IRANGE_SENSE_RST;  // sense switches open
  endtask

  task automatic check_regs();
    check_nib("led", led, shadow[0]);
    check_nib("dac", dac, shadow[1]);
    check_nib("rails", rails, shadow[2]);
    check_nib("adc", adc, shadow[3]);
    check_nib("clamp", clamp, shadow[4]);
    check_nib("relay", relay, shadow[5]);
    check_nib("irange_sense", irange_sense, shadow[6]);
  endtask

  // mux at reset value selects no part in peripheral mode
  task automatic check_mux_clear();
    special_n   = 1'b1;
    periph_miso = '1;
    cs_n        = 1'b0;
    wait_clks(1);
    check_periph("periph_cs_n", periph_cs_n, '1);
    check_bit("miso", miso, 1'b0);
    cs_n        = 1'b1;
    special_n   = 1'b0;
    periph_miso = '0;
    wait_clks(10);
  endtask

  ////////////////////////////////////////////////////////////
  // SPI master, mode 0, MSB first

  task automatic send_frame(input frame_t f, input int nbits, input logic spec_n,
                            output frame_t got);
    got       = '0;
    special_n = spec_n;
    wait_clks(half_bit);
    cs_n = 1'b0;
    wait_clks(half_bit);  // dout loads on cs fall
    for (int i = 0; i < nbits; i++)
    begin
      mosi = (i < `SPI_FRAME_BITS) ? f[`SPI_FRAME_BITS-1-i] : 1'b0;  // pad long frames
      wait_clks(half_bit);
      got  = {got[`SPI_FRAME_BITS-2:0], miso};  // sample ahead of rising edge
      check_bit("periph_mosi", periph_mosi, mosi);
      sclk = 1'b1;
      wait_clks(half_bit);
      check_bit("periph_sclk", periph_sclk, 1'b1);
      sclk = 1'b0;
    end
    wait_clks(half_bit);
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_clks(10);  // registers sampled here
    special_n = 1'b0;
  endtask

  // write mux exactly, then toggle cs_n in peripheral mode
  task automatic check_routing(input nib_t m, input periph_vec_t exp_cs);
    frame_t      got;
    periph_vec_t pat;
    send_frame({addr_t'(`ADDR_MUX), ~m, m}, `SPI_FRAME_BITS, 1'b0, got);
    check_frame("miso readback", got, last_rb);
    last_rb   = {addr_t'(`ADDR_MUX), 4'h0, m};
    special_n = 1'b1;
    for (int k = 0; k < 4; k++)
    begin
      pat         = periph_vec_t'($random(seed));
      periph_miso = pat;
      cs_n        = 1'b1;
      wait_clks(1);
      check_periph("periph_cs_n", periph_cs_n, '1);  // host deselected
      cs_n = 1'b0;
      wait_clks(1);
      check_periph("periph_cs_n", periph_cs_n, exp_cs);
      check_bit("miso", miso, |(~exp_cs & pat));
    end
    cs_n = 1'b1;
    wait_clks(half_bit);
    special_n = 1'b0;
    wait_clks(10);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int          kind;
    logic [15:0] a_w, b_w, c_w, d_w;
    frame_t      got;
    arst_n      = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    special_n   = 1'b0;
    mosi        = 1'b0;
    periph_miso = '0;
    seed        = 32'h3ce8;
    last_rb     = '0;  // bank readback out of reset
    foreach (vec_mem[i])
      vec_mem[i] = '0;  // kind 0 ends the list
    $readmemh("dv/spi_ctrl_input.txt", vec_mem);
    num_recs = 0;
    while (num_recs < max_recs && vec_mem[num_recs*rec_words] != 16'h0)
      num_recs++;
    loaded = 1'b1;
    wait_clks(16);
    arst_n = 1'b1;
    wait_clks(4);
    reset_shadow();
    check_regs();
    check_mux_clear();
    for (int r = 0; r < num_recs; r++)
    begin
      kind = int'(vec_mem[r*rec_words]);
      a_w  = vec_mem[r*rec_words+1];
      b_w  = vec_mem[r*rec_words+2];
      c_w  = vec_mem[r*rec_words+3];
      d_w  = vec_mem[r*rec_words+4];
      case (kind)
        1:
        begin
          send_frame(a_w, `SPI_FRAME_BITS, 1'b0, got);
          check_frame("miso readback", got, last_rb);  // result of previous frame
          last_rb = d_w;
          if (b_w == 16'hf)
            reset_shadow();
          else if (b_w < 16'd7)
            shadow[b_w[2:0]] = c_w[3:0];
          check_regs();
          if (b_w == 16'hf)
            check_mux_clear();
        end
        2:
        begin
          send_frame(a_w, int'(b_w), c_w[0], got);
          check_regs();  // discarded frame leaves regs alone
        end
        3: check_routing(a_w[3:0], b_w[3:0]);
        default: stop_fail("stimulus file holds an unknown record kind");
      endcase
    end
    if (spi_ctrl_top_inst.spi_ctrl_properties_inst.failed)
      stop_fail("assertion failures were reported");
    else
    begin
      $display(">>> PASS");
      $finish;
    end
  end

  // bound by stimulus length
  initial
  begin
    wait (loaded);
    repeat (num_recs * 200 + 1000) @(posedge clk);
    stop_fail("watchdog expired before the stimulus finished");
  end

endmodule

// File: dv/spi_ctrl_properties.sv
////////////////////////////////////////////////////////////
// control FPGA top checks
// frame strobe width, cs gating, register hold
////////////////////////////////////////////////////////////

module spi_ctrl_properties (
  input logic                      clk,
  input logic                      arst_n,
  input logic                      special_n,
  input logic                      frame_valid,
  input ctrl_reg_pkg::periph_vec_t periph_cs_n,
  input ctrl_reg_pkg::nib_t        led,
  input ctrl_reg_pkg::nib_t        mux,
  input ctrl_reg_pkg::nib_t        dac,
  input ctrl_reg_pkg::nib_t        rails,
  input ctrl_reg_pkg::nib_t        adc,
  input ctrl_reg_pkg::nib_t        clamp,
  input ctrl_reg_pkg::nib_t        relay,
  input ctrl_reg_pkg::nib_t        irange_sense
);

  int   strobe_fails = 0;
  int   cs_fails     = 0;
  int   hold_fails   = 0;
  logic failed;  // any assertion tripped

  assign failed = (strobe_fails + cs_fails + hold_fails) != 0;

  // one pulse per accepted frame
  a_single_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |=> !frame_valid)
  else
  begin
    strobe_fails = strobe_fails + 1;
    $error("frame_valid high on two cycles in a row");
  end

  // bank access keeps every part off the bus
  a_cs_gated: assert property (@(posedge clk) disable iff (!arst_n)
    !special_n |-> &periph_cs_n)
  else
  begin
    cs_fails = cs_fails + 1;
    $error("peripheral chip select low while special_n low");
  end

  a_regs_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !frame_valid |=> $stable({led, mux, dac, rails, adc, clamp, relay, irange_sense}))
  else
  begin
    hold_fails = hold_fails + 1;
    $error("register changed without frame_valid");
  end

endmodule

bind spi_ctrl_top spi_ctrl_properties spi_ctrl_properties_inst (
  .clk          (clk),
  .arst_n       (arst_n),
  .special_n    (special_n),
  .frame_valid  (frame_valid),
  .periph_cs_n  (periph_cs_n),
  .led          (led),
  .mux          (mux),
  .dac          (dac),
  .rails        (rails),
  .adc          (adc),
  .clamp        (clamp),
  .relay        (relay),
  .irange_sense (irange_sense)
);

// File: rtl/spi_ctrl_top.sv
////////////////////////////////////////////////////////////
// source-measure board control FPGA top
// host SPI receiver, control register bank, peripheral router
////////////////////////////////////////////////////////////

module spi_ctrl_top (
  input  logic                      clk,
  input  logic                      arst_n,
  // host
  input  logic                      sclk,
  input  logic                      cs_n,
  input  logic                      special_n,
  input  logic                      mosi,
  output logic                      miso,
  // peripherals
  output ctrl_reg_pkg::periph_vec_t periph_cs_n,
  input  ctrl_reg_pkg::periph_vec_t periph_miso,
  output logic                      periph_sclk,
  output logic                      periph_mosi,
  // register outputs
  output ctrl_reg_pkg::nib_t        led,
  output ctrl_reg_pkg::nib_t        dac,
  output ctrl_reg_pkg::nib_t        rails,
  output ctrl_reg_pkg::nib_t        adc,
  output ctrl_reg_pkg::nib_t        clamp,
  output ctrl_reg_pkg::nib_t        relay,
  output ctrl_reg_pkg::nib_t        irange_sense
);

  import spi_frame_pkg::*;
  import ctrl_reg_pkg::*;

  logic   frame_valid;
  frame_t frame;
  frame_t readback;  // last write, shifted out on next frame
  logic   dout;      // bank MISO before routing
  nib_t   mux;

  // clock and data go straight to every part
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  spi_frame_rx spi_frame_rx_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .readback    (readback),
    .frame_valid (frame_valid),
    .frame       (frame),
    .dout        (dout)
  );

  ctrl_reg_bank ctrl_reg_bank_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .frame_valid  (frame_valid),
    .frame        (frame),
    .led          (led),
    .mux          (mux),
    .dac          (dac),
    .rails        (rails),
    .adc          (adc),
    .clamp        (clamp),
    .relay        (relay),
    .irange_sense (irange_sense),
    .readback     (readback)
  );

  // raw host cs_n, no sync delay on the peripheral path
  periph_spi_router periph_spi_router_inst (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mux         (mux),
    .dout        (dout),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

// File: rtl/periph_spi_router.sv
////////////////////////////////////////////////////////////
// peripheral SPI router
// host cs_n to selected parts, MISO source select
////////////////////////////////////////////////////////////

`include "spi_ctrl_cfg.svh"

module periph_spi_router (
  input  logic                       cs_n,
  input  logic                       special_n,
  input  ctrl_reg_pkg::nib_t         mux,
  input  logic                       dout,
  input  ctrl_reg_pkg::periph_vec_t  periph_miso,
  output ctrl_reg_pkg::periph_vec_t  periph_cs_n,
  output logic                       miso
);

  // purely combinational, cs follows host pin directly
  always_comb
  begin
    if (special_n)
    begin
      // peripheral mode
      // selected parts see cs_n, the rest stay deselected
      periph_cs_n = ~(mux & {`PERIPH_NUM{~cs_n}});
      miso        = |(mux & periph_miso);  // OR of selected parts
    end
    else
    begin
      // bank access, keep every part off the bus
      periph_cs_n = '1;
      miso        = dout;
    end
  end

  // mux = 0 in peripheral mode -> nothing selected, miso 0
  // a spurious write to a peripheral during a bank frame
  // cannot happen since all selects are forced high above

endmodule

// File: rtl/ctrl_reg_bank.sv
////////////////////////////////////////////////////////////
// control register bank
// set/clear/toggle updates, soft reset, readback of last write
////////////////////////////////////////////////////////////

`include "spi_ctrl_cfg.svh"

module ctrl_reg_bank (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  frame_valid,
  input  spi_frame_pkg::frame_t frame,
  output ctrl_reg_pkg::nib_t    led,
  output ctrl_reg_pkg::nib_t    mux,
  output ctrl_reg_pkg::nib_t    dac,
  output ctrl_reg_pkg::nib_t    rails,
  output ctrl_reg_pkg::nib_t    adc,
  output ctrl_reg_pkg::nib_t    clamp,
  output ctrl_reg_pkg::nib_t    relay,
  output ctrl_reg_pkg::nib_t    irange_sense,
  output spi_frame_pkg::frame_t readback
);

  import spi_frame_pkg::*;
  import ctrl_reg_pkg::*;

  localparam int pad_bits = `SPI_FRAME_BITS - `SPI_ADDR_BITS - `CTRL_REG_BITS;

  addr_t addr;
  data_t val;
  nib_t  set_m, clr_m;
  nib_t  cur;     // old value of addressed reg
  nib_t  nxt;     // updated value
  logic  hit;     // address maps to a register

  // set wins nothing, overlap means toggle
  function automatic nib_t upd(nib_t old, nib_t set_b, nib_t clr_b);
    nib_t both;
    both = set_b & clr_b;
    if (|both)
      upd = old ^ both;
    else
      upd = (old | set_b) & ~clr_b;
  endfunction

  assign addr  = frame[`SPI_FRAME_BITS-1:`SPI_FRAME_BITS-`SPI_ADDR_BITS];
  assign val   = frame[`SPI_FRAME_BITS-`SPI_ADDR_BITS-1:0];
  assign set_m = val[`CTRL_REG_BITS-1:0];       // low nibble
  assign clr_m = val[2*`CTRL_REG_BITS-1:`CTRL_REG_BITS];  // high nibble

  ////////////////////////////////////////////////////////////
  // address decode

  always_comb
  begin
    cur = '0;
    hit = 1'b1;
    case (addr)
      `ADDR_LED:          cur = led;
      `ADDR_MUX:          cur = mux;
      `ADDR_DAC:          cur = dac;
      `ADDR_RAILS:        cur = rails;
      `ADDR_ADC:          cur = adc;
      `ADDR_CLAMP:        cur = clamp;
      `ADDR_RELAY:        cur = relay;
      `ADDR_IRANGE_SENSE: cur = irange_sense;
      default:            hit = 1'b0;  // soft reset lands here too
    endcase
  end

  assign nxt = upd(cur, set_m, clr_m);

  ////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      led          <= '0;
      mux          <= '0;  // no peripheral selected
      dac          <= '0;
      rails        <= '0;
      adc          <= '0;
      clamp        <= '0;
      relay        <= '0;
      irange_sense <= `IRANGE_SENSE_RST;
      readback     <= '0;
    end
    else if (frame_valid)
    begin
      case (addr)
        `ADDR_LED:          led          <= nxt;
        `ADDR_MUX:          mux          <= nxt;
        `ADDR_DAC:          dac          <= nxt;
        `ADDR_RAILS:        rails        <= nxt;
        `ADDR_ADC:          adc          <= nxt;
        `ADDR_CLAMP:        clamp        <= nxt;
        `ADDR_RELAY:        relay        <= nxt;
        `ADDR_IRANGE_SENSE: irange_sense <= nxt;
        `ADDR_SOFT_RST:
        begin
          led          <= '0;
          mux          <= '0;
          dac          <= '0;
          rails        <= '0;
          adc          <= '0;
          clamp        <= '0;
          relay        <= '0;
          irange_sense <= `IRANGE_SENSE_RST;
        end
        default: ;  // unknown address, ignore
      endcase
      // addr in high byte, result in low nibble
      readback <= hit ? {addr, {pad_bits{1'b0}}, nxt} : '0;
    end
  end

endmodule

// File: rtl/spi_frame_rx.sv
////////////////////////////////////////////////////////////
// host SPI frame receiver
// syncs host lines into clk, shifts frames in, readback out
////////////////////////////////////////////////////////////

`include "spi_ctrl_cfg.svh"

module spi_frame_rx (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  special_n,
  input  logic                  mosi,
  input  spi_frame_pkg::frame_t readback,
  output logic                  frame_valid,
  output spi_frame_pkg::frame_t frame,
  output logic                  dout
);

  import spi_frame_pkg::*;

  localparam int cnt_bits = $clog2(`SPI_FRAME_BITS) + 1;  // room to see 17+
  localparam logic [cnt_bits-1:0] cnt_max = '1;
  localparam logic [cnt_bits-1:0] cnt_full = cnt_bits'(`SPI_FRAME_BITS);
  localparam logic [3:0] sync_rst = 4'b0110;  // {sclk, cs_n, special_n, mosi} idle

  logic [3:0] sync_q1;  // metastable stage
  logic [3:0] sync_q2;
  logic       sclk_s, cs_n_s, special_n_s, mosi_s;
  logic       sclk_d, cs_n_d;  // for edge detect
  logic       sclk_rise, sclk_fall, cs_fall, cs_rise;
  logic       accept;

  rx_state_e           state;
  logic [cnt_bits-1:0] bit_cnt;
  logic                bad;        // special_n seen high during frame
  frame_t              shift_in;
  frame_t              shift_out;

  ////////////////////////////////////////////////////////////
  // synchronizer and edge detect

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_q1 <= sync_rst;
      sync_q2 <= sync_rst;
      sclk_d  <= 1'b0;
      cs_n_d  <= 1'b1;
    end
    else
    begin
      sync_q1 <= {sclk, cs_n, special_n, mosi};
      sync_q2 <= sync_q1;
      sclk_d  <= sclk_s;
      cs_n_d  <= cs_n_s;
    end
  end

  assign {sclk_s, cs_n_s, special_n_s, mosi_s} = sync_q2;

  assign sclk_rise = sclk_s & ~sclk_d;
  assign sclk_fall = ~sclk_s & sclk_d;
  assign cs_fall   = ~cs_n_s & cs_n_d;
  assign cs_rise   = cs_n_s & ~cs_n_d;

  // exactly 16 edges, special held low the whole way
  assign accept = (state == rx_shift) && cs_rise && !bad && (bit_cnt == cnt_full);

  ////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state       <= rx_idle;
      bit_cnt     <= '0;
      bad         <= 1'b0;
      frame_valid <= 1'b0;
      dout        <= 1'b0;
    end
    else
    begin
      frame_valid <= accept;  // single pulse, state leaves rx_shift
      case (state)
        rx_idle:
          if (cs_fall)
          begin
            state   <= rx_shift;
            bit_cnt <= '0;
            bad     <= special_n_s;
            dout    <= readback[`SPI_FRAME_BITS-1];  // MSB ready before first rise
          end
        rx_shift:
          if (cs_rise)
            state <= rx_done;
          else
          begin
            if (special_n_s)
              bad <= 1'b1;
            if (sclk_rise && bit_cnt != cnt_max)
              bit_cnt <= bit_cnt + 1'b1;  // saturate, long frames stay bad
            if (sclk_fall)
              dout <= shift_out[`SPI_FRAME_BITS-1];
          end
        rx_done:
        begin
          state <= rx_idle;
          dout  <= 1'b0;
        end
        default: state <= rx_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // data shifters

  always_ff @(posedge clk)
  begin
    if (state == rx_idle && cs_fall)
      shift_out <= readback << 1;  // MSB already on dout
    else if (state == rx_shift && sclk_fall)
      shift_out <= shift_out << 1;

    if (state == rx_shift && sclk_rise)
      shift_in <= {shift_in[`SPI_FRAME_BITS-2:0], mosi_s};  // MSB first

    if (accept)
      frame <= shift_in;  // held until next accepted frame
  end

endmodule

// File: rtl/ctrl_reg_pkg.sv
////////////////////////////////////////////////////////////
// control register types
// register nibble and peripheral select vector
////////////////////////////////////////////////////////////

`include "spi_ctrl_cfg.svh"

package ctrl_reg_pkg;

  // one control register
  // also used for the set and clear halves of a value byte
  typedef logic [`CTRL_REG_BITS-1:0] nib_t;

  // one bit per external peripheral
  // chip selects (active low) and MISO lines
  typedef logic [`PERIPH_NUM-1:0] periph_vec_t;

  // register encoding, bit i of mux selects peripheral i
  //   bit 0  adc03
  //   bit 1  dac
  //   bit 2  flash
  //   bit 3  adc02
  // several bits may be set at once, cs goes to all of them
  // and their MISO lines are OR'ed back to the host

endpackage

// File: rtl/spi_frame_pkg.sv
////////////////////////////////////////////////////////////
// host SPI frame types
// frame layout and receiver FSM states
////////////////////////////////////////////////////////////

`include "spi_ctrl_cfg.svh"

package spi_frame_pkg;

  // whole frame as shifted in, MSB first
  typedef logic [`SPI_FRAME_BITS-1:0] frame_t;

  // high byte, register address
  typedef logic [`SPI_ADDR_BITS-1:0] addr_t;

  // low byte, clear mask in high nibble, set mask in low nibble
  typedef logic [`SPI_FRAME_BITS-`SPI_ADDR_BITS-1:0] data_t;

  // receiver FSM
  typedef enum logic [1:0] {
    rx_idle,   // waiting for cs_n fall
    rx_shift,  // counting sclk edges
    rx_done    // one cycle after cs_n rise
  } rx_state_e;

endpackage

// File: include/spi_ctrl_cfg.svh
////////////////////////////////////////////////////////////
// control FPGA configuration
// frame geometry, register map and reset values
////////////////////////////////////////////////////////////

`ifndef SPI_CTRL_CFG_SVH
`define SPI_CTRL_CFG_SVH

////////////////////////////////////////////////////////////
// frame geometry
`define SPI_FRAME_BITS 16   // address byte + value byte
`define SPI_ADDR_BITS  8    // high byte of frame
`define CTRL_REG_BITS  4    // one register, also set/clear mask width

// external SPI parts behind the single host chip select
`define PERIPH_NUM     4

////////////////////////////////////////////////////////////
// register map
`define ADDR_LED          7
`define ADDR_MUX          8   // peripheral select
`define ADDR_DAC          9
`define ADDR_RAILS        10
`define ADDR_SOFT_RST     11  // write anything, all regs back to reset
`define ADDR_ADC          14
`define ADDR_CLAMP        15
`define ADDR_RELAY        19
`define ADDR_IRANGE_SENSE 20

////////////////////////////////////////////////////////////
// reset values
// sense switches default open, everything else zero
`define IRANGE_SENSE_RST  4'b1111

`endif
